// File: fifo_flags_pkg.sv
//==========================================================================
// FIFO flag controller definitions
// Shared widths, depth, pointer arithmetic, the mode register layout and
// the Wishbone request and response bundles used by the flag controller
//==========================================================================

package fifo_flags_pkg;

  //==========================================================================
  // Sizes
  //==========================================================================

  // Number of storage entries outside this block
  localparam int fifo_depth = 7;

  // A 3-bit Gray pointer has 8 codes, enough to show 0 to 7 filled entries
  localparam int ptr_width = 3;

  // Storage addresses count 0 to 6 and wrap
  localparam int addr_width = 3;

  typedef logic [ptr_width-1:0]  gray_ptr_t;
  typedef logic [addr_width-1:0] fifo_addr_t;

  //==========================================================================
  // Pointer arithmetic
  //==========================================================================

  // Next code in the reflected Gray sequence
  // 000, 001, 011, 010, 110, 111, 101, 100 and back to 000
  function automatic gray_ptr_t gray_inc(input gray_ptr_t ptr);
    case (ptr)
      3'b000:  gray_inc = 3'b001;
      3'b001:  gray_inc = 3'b011;
      3'b011:  gray_inc = 3'b010;
      3'b010:  gray_inc = 3'b110;
      3'b110:  gray_inc = 3'b111;
      3'b111:  gray_inc = 3'b101;
      3'b101:  gray_inc = 3'b100;
      // Code 100 is the last one and wraps back to zero
      default: gray_inc = 3'b000;
    endcase
  endfunction

  // Storage address step, modulo the depth rather than the pointer range
  function automatic fifo_addr_t addr_inc(input fifo_addr_t addr);
    if (addr == fifo_addr_t'(fifo_depth - 1))
    begin
      addr_inc = '0;
    end
    else
    begin
      addr_inc = addr + 1'b1;
    end
  endfunction

  //==========================================================================
  // Mode register
  //==========================================================================

  // Bit 3 selects two sync stages on the write pointer seen by the reader
  // Bit 2 selects two sync stages on the read pointer seen by the writer
  // Bit 1 writes data one clock before the write flag moves
  // Bit 0 raises the read flag one clock before data is read
  typedef struct packed {
    logic double_sync_write_ptr;
    logic double_sync_read_ptr;
    logic write_data_before_flag;
    logic read_flag_before_data;
  } mode_cfg_t;

  // Register map, one address bit wide
  // Address 0 holds the mode in data bits 3:0, bits 7:4 read as zero
  // Address 1 is unused, acks, ignores writes and reads as zero
  localparam logic mode_reg_addr = 1'b0;

  // Single sync on both sides with data written ahead of the flag
  localparam mode_cfg_t mode_reset_value = '{
    double_sync_write_ptr:  1'b0,
    double_sync_read_ptr:   1'b0,
    write_data_before_flag: 1'b1,
    read_flag_before_data:  1'b0
  };

  //==========================================================================
  // Wishbone classic bundles
  //==========================================================================

  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic       adr;
    logic [7:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic       ack;
    logic [7:0] dat;
  } wb_rsp_t;

endpackage

// File: pointer_sync.sv
//==========================================================================
// Gray pointer synchronizer
// Brings one Gray pointer into the receiving clock, one flop per bit in
// each stage, with one or two stages picked by a mode bit
//==========================================================================

`timescale 1ns/1ns

module pointer_sync (
  input  logic                      clk,
  input  logic                      reset_flags_async,
  input  logic                      double_sync,
  input  fifo_flags_pkg::gray_ptr_t ptr_in,
  output fifo_flags_pkg::gray_ptr_t ptr_sync
);
  import fifo_flags_pkg::*;

  // First stage may go metastable, the second gives it a full clock to settle
  gray_ptr_t sync_stage1;
  gray_ptr_t sync_stage2;

  // Only one pointer bit moves per step, so sampling each bit on its own
  // lands on either the old or the new code and never on a mix
  always_ff @(posedge clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      sync_stage1 <= '0;
      sync_stage2 <= '0;
    end
    else
    begin
      sync_stage1 <= ptr_in;
      sync_stage2 <= sync_stage1;
    end
  end

  // A slow receiving clock can use the first stage directly
  // A fast one needs the extra stage to meet settling time
  assign ptr_sync = double_sync ? sync_stage2 : sync_stage1;

endmodule

// File: fifo_write_flags.sv
//==========================================================================
// FIFO write side flags
// Keeps the write Gray pointer and storage address, tells the writer when
// there is room, strobes data capture and reports submits while full
//==========================================================================

`timescale 1ns/1ns

module fifo_write_flags (
  input  logic                       write_clk,
  input  logic                       reset_flags_async,
  input  fifo_flags_pkg::mode_cfg_t  mode,
  input  logic                       write_submit,
  input  fifo_flags_pkg::gray_ptr_t  read_ptr_sync,
  output fifo_flags_pkg::gray_ptr_t  write_ptr,
  output fifo_flags_pkg::fifo_addr_t write_address,
  output logic                       write_capture_data,
  output logic                       write_room_available,
  output logic                       write_error
);
  import fifo_flags_pkg::*;

  gray_ptr_t next_write_ptr;
  logic      write_not_full;
  logic      write_accept;
  logic      write_advance;
  // Set for the clock after a capture, while the flag has not moved yet
  logic      write_holdoff;

  //==========================================================================
  // Room check
  //==========================================================================

  // Full when one more step would land on the reader's pointer
  // The reader's pointer is a synchronized copy and may lag, which only
  // makes the writer more careful
  assign next_write_ptr = gray_inc(write_ptr);
  assign write_not_full = (next_write_ptr != read_ptr_sync);

  // In data-before-flag mode the pointer is stale during the holdoff clock,
  // so room is withheld until it catches up
  assign write_room_available = write_not_full
                              & ~(mode.write_data_before_flag & write_holdoff);

  // The storage captures on the same clock as the accepted submit
  assign write_accept       = write_submit & write_room_available;
  assign write_capture_data = write_accept;

  // Pointer moves with the data, or one clock after it
  assign write_advance = mode.write_data_before_flag ? write_holdoff : write_accept;

  //==========================================================================
  // Pointer, address and error flops
  //==========================================================================

  always_ff @(posedge write_clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      write_holdoff <= 1'b0;
      write_ptr     <= '0;
      write_address <= '0;
      write_error   <= 1'b0;
    end
    else
    begin
      write_holdoff <= write_accept;
      if (write_advance)
      begin
        write_ptr     <= next_write_ptr;
        write_address <= addr_inc(write_address);
      end
      // One clock pulse for each refused submit
      write_error <= write_submit & ~write_room_available;
    end
  end

  //==========================================================================
  // Checks
  //==========================================================================

  // The reader samples this pointer bit by bit, so it must step one bit
  write_ptr_gray_step: assert property (
    @(posedge write_clk) disable iff (reset_flags_async)
    $countones(write_ptr ^ $past(write_ptr)) <= 1
  );

  write_address_in_range: assert property (
    @(posedge write_clk) disable iff (reset_flags_async)
    write_address < fifo_depth
  );

endmodule

// File: fifo_read_flags.sv
//==========================================================================
// FIFO read side flags
// Keeps the read Gray pointer and storage address, tells the reader when
// data is there, drives the storage read enable and reports bad removes
//==========================================================================

`timescale 1ns/1ns

module fifo_read_flags (
  input  logic                       read_clk,
  input  logic                       reset_flags_async,
  input  fifo_flags_pkg::mode_cfg_t  mode,
  input  logic                       read_remove,
  input  fifo_flags_pkg::gray_ptr_t  write_ptr_sync,
  output fifo_flags_pkg::gray_ptr_t  read_ptr,
  output fifo_flags_pkg::fifo_addr_t read_address,
  output logic                       read_enable,
  output logic                       read_data_available,
  output logic                       read_error
);
  import fifo_flags_pkg::*;

  logic read_not_empty_soon;
  // Copy of the not-empty condition one clock late
  logic read_not_empty_prev;
  logic read_accept;

  //==========================================================================
  // Availability
  //==========================================================================

  // Any difference between the pointers means at least one entry is filled
  assign read_not_empty_soon = (read_ptr != write_ptr_sync);

  // Flag-before-data mode raises the flag a clock late, giving the storage
  // one clock to present the entry after read_enable went high
  assign read_data_available = mode.read_flag_before_data ? read_not_empty_prev
                                                          : read_not_empty_soon;

  // Constant read keeps the storage output live at all times
  // Otherwise the storage is read only once an entry is known to be there
  assign read_enable = ~mode.read_flag_before_data | read_not_empty_soon;

  assign read_accept = read_remove & read_data_available;

  //==========================================================================
  // Pointer, address and error flops
  //==========================================================================

  always_ff @(posedge read_clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      read_not_empty_prev <= 1'b0;
      read_ptr            <= '0;
      read_address        <= '0;
      read_error          <= 1'b0;
    end
    else
    begin
      if (read_accept)
      begin
        // The next entry has not been presented yet, so drop the delayed flag
        read_not_empty_prev <= 1'b0;
        read_ptr            <= gray_inc(read_ptr);
        read_address        <= addr_inc(read_address);
      end
      else
      begin
        read_not_empty_prev <= read_not_empty_soon;
      end
      // One clock pulse for each remove with nothing available
      read_error <= read_remove & ~read_data_available;
    end
  end

  //==========================================================================
  // Checks
  //==========================================================================

  // The writer samples this pointer bit by bit, so it must step one bit
  read_ptr_gray_step: assert property (
    @(posedge read_clk) disable iff (reset_flags_async)
    $countones(read_ptr ^ $past(read_ptr)) <= 1
  );

endmodule

// File: fifo_mode_regs.sv
//==========================================================================
// FIFO flag mode register
// Wishbone classic slave holding the sync depth and timing mode bits that
// steer both sides of the flag controller
//==========================================================================

`timescale 1ns/1ns

module fifo_mode_regs (
  input  logic                      read_clk,
  input  logic                      reset_flags_async,
  input  fifo_flags_pkg::wb_req_t   wb_req,
  output fifo_flags_pkg::wb_rsp_t   wb_rsp,
  output fifo_flags_pkg::mode_cfg_t mode
);
  import fifo_flags_pkg::*;

  logic      wb_request;
  logic      wb_ack;
  logic      mode_hit;
  mode_cfg_t mode_q;

  //==========================================================================
  // Bus decode
  //==========================================================================

  assign wb_request = wb_req.cyc & wb_req.stb;
  assign mode_hit   = (wb_req.adr == mode_reg_addr);

  // Ack rises one clock after the request and falls the clock after,
  // so a request held high is served every second clock
  always_ff @(posedge read_clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      wb_ack <= 1'b0;
    end
    else
    begin
      wb_ack <= wb_request & ~wb_ack;
    end
  end

  //==========================================================================
  // Mode register
  //==========================================================================

  // The write lands on the edge that raises ack
  // Software is expected to change the mode only with the FIFO empty and idle
  always_ff @(posedge read_clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      mode_q <= mode_reset_value;
    end
    else if (wb_request & ~wb_ack & wb_req.we & mode_hit)
    begin
      mode_q <= mode_cfg_t'(wb_req.dat[3:0]);
    end
  end

  assign mode = mode_q;

  // Readback follows the held address, upper bits and the unused slot read 0
  always_comb
  begin
    wb_rsp.ack = wb_ack;
    wb_rsp.dat = mode_hit ? {4'b0000, mode_q} : 8'h00;
  end

  //==========================================================================
  // Checks
  //==========================================================================

  wb_ack_single_cycle: assert property (
    @(posedge read_clk) disable iff (reset_flags_async)
    wb_ack |=> !wb_ack
  );

  // With data and flag moving together on both sides the reader could see
  // the flag before the storage holds the data
  mode_legal_timing: assert property (
    @(posedge read_clk) disable iff (reset_flags_async)
    mode_q.write_data_before_flag | mode_q.read_flag_before_data
  );

endmodule

// File: fifo_flags_top.sv
//==========================================================================
// FIFO flag controller top
// Joins the mode register, the write and read flag sides and the two
// pointer synchronizers that carry occupancy across the clock boundary
//==========================================================================

`timescale 1ns/1ns

module fifo_flags_top (
  input  logic                       write_clk,
  input  logic                       read_clk,
  input  logic                       reset_flags_async,
  input  fifo_flags_pkg::wb_req_t    wb_req,
  output fifo_flags_pkg::wb_rsp_t    wb_rsp,
  input  logic                       write_submit,
  output logic                       write_capture_data,
  output logic                       write_room_available,
  output fifo_flags_pkg::fifo_addr_t write_address,
  output logic                       write_error,
  input  logic                       read_remove,
  output logic                       read_enable,
  output logic                       read_data_available,
  output fifo_flags_pkg::fifo_addr_t read_address,
  output logic                       read_error
);
  import fifo_flags_pkg::*;

  mode_cfg_t mode;
  gray_ptr_t write_ptr;
  gray_ptr_t write_ptr_sync;
  gray_ptr_t read_ptr;
  gray_ptr_t read_ptr_sync;

  // Mode bits live in the read clock and are only changed while idle
  fifo_mode_regs u_mode_regs (
    .read_clk          (read_clk),
    .reset_flags_async (reset_flags_async),
    .wb_req            (wb_req),
    .wb_rsp            (wb_rsp),
    .mode              (mode)
  );

  fifo_write_flags u_write_flags (
    .write_clk            (write_clk),
    .reset_flags_async    (reset_flags_async),
    .mode                 (mode),
    .write_submit         (write_submit),
    .read_ptr_sync        (read_ptr_sync),
    .write_ptr            (write_ptr),
    .write_address        (write_address),
    .write_capture_data   (write_capture_data),
    .write_room_available (write_room_available),
    .write_error          (write_error)
  );

  fifo_read_flags u_read_flags (
    .read_clk            (read_clk),
    .reset_flags_async   (reset_flags_async),
    .mode                (mode),
    .read_remove         (read_remove),
    .write_ptr_sync      (write_ptr_sync),
    .read_ptr            (read_ptr),
    .read_address        (read_address),
    .read_enable         (read_enable),
    .read_data_available (read_data_available),
    .read_error          (read_error)
  );

  // Write pointer into the read clock
  pointer_sync u_sync_to_read (
    .clk               (read_clk),
    .reset_flags_async (reset_flags_async),
    .double_sync       (mode.double_sync_write_ptr),
    .ptr_in            (write_ptr),
    .ptr_sync          (write_ptr_sync)
  );

  // Read pointer into the write clock
  pointer_sync u_sync_to_write (
    .clk               (write_clk),
    .reset_flags_async (reset_flags_async),
    .double_sync       (mode.double_sync_read_ptr),
    .ptr_in            (read_ptr),
    .ptr_sync          (read_ptr_sync)
  );

endmodule

// File: tb_fifo_flags_table.svh
//==========================================================================
// FIFO flag controller scenario table
// One row per scenario with the mode word to program, the transfer counts,
// the probes that follow and the results the testbench expects
//==========================================================================

`ifndef TB_FIFO_FLAGS_TABLE_SVH
`define TB_FIFO_FLAGS_TABLE_SVH

typedef struct packed {
  logic [7:0] mode_word;
  logic [7:0] write_count;
  logic [7:0] read_count;
  logic       streaming;
  logic       overflow_check;
  logic       underflow_check;
  logic       expect_full;
  logic [7:0] expected_readback;
} scenario_t;

localparam int num_scenarios = 17;

// Columns are mode, writes, reads, streaming, overflow probe, underflow
// probe, room expected low after the writes, expected mode readback
localparam scenario_t scenario_table [num_scenarios] = '{
  // Fill to the top and drain in every legal timing and sync combination
  '{8'h01, 8'd7, 8'd7, 1'b0, 1'b1, 1'b1, 1'b1, 8'h01},
  '{8'h02, 8'd7, 8'd7, 1'b0, 1'b1, 1'b1, 1'b1, 8'h02},
  '{8'h03, 8'd7, 8'd7, 1'b0, 1'b1, 1'b1, 1'b1, 8'h03},
  '{8'h05, 8'd7, 8'd7, 1'b0, 1'b1, 1'b1, 1'b1, 8'h05},
  '{8'h06, 8'd7, 8'd7, 1'b0, 1'b1, 1'b1, 1'b1, 8'h06},
  '{8'h07, 8'd7, 8'd7, 1'b0, 1'b1, 1'b1, 1'b1, 8'h07},
  '{8'h09, 8'd7, 8'd7, 1'b0, 1'b1, 1'b1, 1'b1, 8'h09},
  '{8'h0a, 8'd7, 8'd7, 1'b0, 1'b1, 1'b1, 1'b1, 8'h0a},
  '{8'h0b, 8'd7, 8'd7, 1'b0, 1'b1, 1'b1, 1'b1, 8'h0b},
  '{8'h0d, 8'd7, 8'd7, 1'b0, 1'b1, 1'b1, 1'b1, 8'h0d},
  '{8'h0e, 8'd7, 8'd7, 1'b0, 1'b1, 1'b1, 1'b1, 8'h0e},
  '{8'h0f, 8'd7, 8'd7, 1'b0, 1'b1, 1'b1, 1'b1, 8'h0f},
  // A partial fill leaves room for more
  '{8'h02, 8'd3, 8'd3, 1'b0, 1'b0, 1'b0, 1'b0, 8'h02},
  // Twenty items with random gaps on both sides, wrapping the addresses
  '{8'h01, 8'd20, 8'd20, 1'b1, 1'b0, 1'b0, 1'b0, 8'h01},
  '{8'h0e, 8'd20, 8'd20, 1'b1, 1'b0, 1'b0, 1'b0, 8'h0e},
  '{8'h0b, 8'd20, 8'd20, 1'b1, 1'b0, 1'b0, 1'b0, 8'h0b},
  '{8'h06, 8'd20, 8'd20, 1'b1, 1'b0, 1'b0, 1'b0, 8'h06}
};

`endif

// File: tb_fifo_flags.sv
//==========================================================================
// FIFO flag controller testbench
// Runs the scenario table against the flag controller with both clocks
// tied together and checks handshakes and addresses against a model
//==========================================================================

`timescale 1ns/1ns

module tb_fifo_flags;
  import fifo_flags_pkg::*;

  `include "tb_fifo_flags_table.svh"

  // Storage depth as the model sees it
  localparam int model_depth = 7;

  logic       clk;
  logic       reset_flags_async;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;
  logic       write_submit;
  logic       write_capture_data;
  logic       write_room_available;
  fifo_addr_t write_address;
  logic       write_error;
  logic       read_remove;
  logic       read_enable;
  logic       read_data_available;
  fifo_addr_t read_address;
  logic       read_error;

  // Accepted transfers since reset, from which the model predicts addresses
  int         write_total;
  int         read_total;
  int         cycle_count;
  int         cycle_limit;
  fifo_addr_t write_seen [$];
  fifo_addr_t read_seen [$];
  logic [7:0] read_data;

  // Both flag sides share one clock, the equal-clock mode of the source design
  fifo_flags_top u_fifo_flags_top (
    .write_clk            (clk),
    .read_clk             (clk),
    .reset_flags_async    (reset_flags_async),
    .wb_req               (wb_req),
    .wb_rsp               (wb_rsp),
    .write_submit         (write_submit),
    .write_capture_data   (write_capture_data),
    .write_room_available (write_room_available),
    .write_address        (write_address),
    .write_error          (write_error),
    .read_remove          (read_remove),
    .read_enable          (read_enable),
    .read_data_available  (read_data_available),
    .read_address         (read_address),
    .read_error           (read_error)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #5 clk = ~clk;
    end
  end

  //==========================================================================
  // Checks and bus access
  //==========================================================================

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t ns %s expected %0h actual %0h",
               $time, name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "stopped at the first error");
    end
  endtask

  // Ack must rise exactly one clock after the request and last one clock
  task automatic wb_access(input logic we, input logic adr, input logic [7:0] wdat,
                           output logic [7:0] rdat);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    @(negedge clk);
    check_value("wb_rsp.ack in request cycle", 32'd0, 32'(wb_rsp.ack));
    @(negedge clk);
    check_value("wb_rsp.ack", 32'd1, 32'(wb_rsp.ack));
    rdat = wb_rsp.dat;
    @(posedge clk);
    wb_req <= '0;
    @(negedge clk);
    check_value("wb_rsp.ack after transfer", 32'd0, 32'(wb_rsp.ack));
  endtask

  // Count clock edges from the edge that sampled a transfer until a flag
  // rises, as seen at the falling edges that follow
  task automatic measure_flag_latency(input string name, input logic room_side,
                                      input int expected);
    int edges;
    edges = 0;
    @(negedge clk);
    while (!(room_side ? write_room_available : read_data_available) && edges < 8)
    begin
      @(negedge clk);
      edges++;
    end
    check_value(name, 32'(expected), 32'(edges));
  endtask

  //==========================================================================
  // Writer and reader
  //==========================================================================

  // Submit only in a cycle that follows an idle cycle with room seen high
  // Nothing can take that room away across the next edge
  task automatic write_one();
    @(negedge clk);
    while (!write_room_available)
      @(negedge clk);
    @(posedge clk);
    write_submit <= 1'b1;
    @(negedge clk);
    check_value("write_capture_data", 32'd1, 32'(write_capture_data));
    check_value("write_address", 32'(write_total % model_depth), 32'(write_address));
    write_seen.push_back(write_address);
    write_total++;
    check_value("model fill level at most 7", 32'd1,
                32'(write_total - read_total <= model_depth));
    @(posedge clk);
    write_submit <= 1'b0;
  endtask

  task automatic read_one();
    @(negedge clk);
    while (!read_data_available)
      @(negedge clk);
    @(posedge clk);
    read_remove <= 1'b1;
    @(negedge clk);
    check_value("read_data_available", 32'd1, 32'(read_data_available));
    check_value("read_enable", 32'd1, 32'(read_enable));
    check_value("read_address", 32'(read_total % model_depth), 32'(read_address));
    read_seen.push_back(read_address);
    read_total++;
    check_value("model fill level at least 0", 32'd1, 32'(write_total >= read_total));
    @(posedge clk);
    read_remove <= 1'b0;
  endtask

  task automatic stream_writes(input int count);
    repeat (count)
    begin
      repeat ($urandom_range(3, 0)) @(posedge clk);
      write_one();
    end
  endtask

  task automatic stream_reads(input int count);
    repeat (count)
    begin
      repeat ($urandom_range(3, 0)) @(posedge clk);
      read_one();
    end
  endtask

  // A submit with no room is not captured and gives one error pulse
  task automatic probe_overflow();
    @(posedge clk);
    write_submit <= 1'b1;
    @(negedge clk);
    check_value("write_capture_data when full", 32'd0, 32'(write_capture_data));
    check_value("write_error before pulse", 32'd0, 32'(write_error));
    @(posedge clk);
    write_submit <= 1'b0;
    @(negedge clk);
    check_value("write_error pulse", 32'd1, 32'(write_error));
    @(negedge clk);
    check_value("write_error after pulse", 32'd0, 32'(write_error));
  endtask

  task automatic probe_underflow();
    @(posedge clk);
    read_remove <= 1'b1;
    @(negedge clk);
    check_value("read_error before pulse", 32'd0, 32'(read_error));
    @(posedge clk);
    read_remove <= 1'b0;
    @(negedge clk);
    check_value("read_error pulse", 32'd1, 32'(read_error));
    @(negedge clk);
    check_value("read_error after pulse", 32'd0, 32'(read_error));
  endtask

  //==========================================================================
  // Scenario rows
  //==========================================================================

  task automatic run_scenario(input scenario_t row);
    logic [7:0] readback;
    mode_cfg_t  row_mode;
    write_seen.delete();
    read_seen.delete();
    row_mode = mode_cfg_t'(row.mode_word[3:0]);
    // The mode only changes while the FIFO is empty and idle
    @(negedge clk);
    check_value("write_room_available when idle", 32'd1, 32'(write_room_available));
    check_value("read_data_available when idle", 32'd0, 32'(read_data_available));
    wb_access(1'b1, 1'b0, row.mode_word, readback);
    wb_access(1'b0, 1'b0, 8'h00, readback);
    check_value("mode readback", 32'(row.expected_readback), 32'(readback));
    if (row.streaming)
    begin
      fork
        stream_writes(int'(row.write_count));
        stream_reads(int'(row.read_count));
      join
      for (int i = 0; i < write_seen.size(); i++)
      begin
        check_value("read_address order", 32'(write_seen[i]), 32'(read_seen[i]));
      end
    end
    else
    begin
      write_one();
      // A write into an empty FIFO shows up on the read side after the
      // write holdoff, the sync stages and the read flag delay
      measure_flag_latency("read_data_available latency", 1'b0,
                           int'(row_mode.write_data_before_flag)
                           + (row_mode.double_sync_write_ptr ? 2 : 1)
                           + int'(row_mode.read_flag_before_data));
      repeat (int'(row.write_count) - 1) write_one();
      // Give the last pointer step time to settle before looking at room
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_value("write_room_available after writes", 32'(!row.expect_full),
                  32'(write_room_available));
      if (row.overflow_check)
      begin
        probe_overflow();
      end
      read_one();
      if (row.expect_full)
      begin
        // Room comes back once the read pointer has crossed to the writer
        measure_flag_latency("write_room_available latency", 1'b1,
                             row_mode.double_sync_read_ptr ? 2 : 1);
      end
      repeat (int'(row.read_count) - 1) read_one();
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_value("read_data_available after reads", 32'd0, 32'(read_data_available));
      // Constant read keeps the enable high, otherwise it drops when empty
      check_value("read_enable when empty", 32'(!row_mode.read_flag_before_data),
                  32'(read_enable));
      if (row.underflow_check)
      begin
        probe_underflow();
      end
    end
    // Let the read pointer cross back to the write side
    repeat (4) @(posedge clk);
  endtask

  function automatic int longest_transfer_count();
    int longest;
    longest = 0;
    for (int i = 0; i < num_scenarios; i++)
    begin
      if (int'(scenario_table[i].write_count) > longest)
      begin
        longest = int'(scenario_table[i].write_count);
      end
      if (int'(scenario_table[i].read_count) > longest)
      begin
        longest = int'(scenario_table[i].read_count);
      end
    end
    return longest;
  endfunction

  //==========================================================================
  // Main sequence and watchdog
  //==========================================================================

  initial
  begin
    void'($urandom(32'hffc10fad));
    reset_flags_async = 1'b1;
    wb_req            = '0;
    write_submit      = 1'b0;
    read_remove       = 1'b0;
    write_total       = 0;
    read_total        = 0;
    repeat (4) @(posedge clk);
    reset_flags_async <= 1'b0;
    @(negedge clk);
    check_value("write_capture_data after reset", 32'd0, 32'(write_capture_data));
    check_value("read_data_available after reset", 32'd0, 32'(read_data_available));
    check_value("write_error after reset", 32'd0, 32'(write_error));
    check_value("read_error after reset", 32'd0, 32'(read_error));
    check_value("wb_rsp.ack after reset", 32'd0, 32'(wb_rsp.ack));
    check_value("write_room_available after reset", 32'd1, 32'(write_room_available));
    check_value("write_address after reset", 32'd0, 32'(write_address));
    check_value("read_address after reset", 32'd0, 32'(read_address));
    // Reset mode is single sync on both sides with data ahead of the flag
    wb_access(1'b0, 1'b0, 8'h00, read_data);
    check_value("mode after reset", 32'h02, 32'(read_data));
    // The unused address ignores writes and reads as zero
    wb_access(1'b1, 1'b1, 8'h0f, read_data);
    wb_access(1'b0, 1'b1, 8'h00, read_data);
    check_value("unused address readback", 32'h00, 32'(read_data));
    wb_access(1'b0, 1'b0, 8'h00, read_data);
    check_value("mode after unused write", 32'h02, 32'(read_data));
    for (int i = 0; i < num_scenarios; i++)
    begin
      run_scenario(scenario_table[i]);
    end
    $display("TB PASSED");
    $finish;
  end

  // Each row may take eight clocks per transfer plus setup time
  initial
  begin
    cycle_limit = num_scenarios * (longest_transfer_count() * 8 + 50);
    cycle_count = 0;
    while (cycle_count < cycle_limit)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d clock cycles, the scenarios did not finish", cycle_limit);
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

endmodule

// File: flist.f
+incdir+.
fifo_flags_pkg.sv
pointer_sync.sv
fifo_write_flags.sv
fifo_read_flags.sv
fifo_mode_regs.sv
fifo_flags_top.sv
tb_fifo_flags.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the FIFO flag controller testbench with Verilator, runs it and
# decides pass or fail from the simulation log

set -u

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
sim_binary=sim_tb_fifo_flags
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fifo_flags \
  -f flist.f \
  --Mdir "${obj_dir}" \
  -o "${sim_binary}"
build_status=$?
if [ ${build_status} -ne 0 ]; then
  echo "Verilator build failed with status ${build_status}"
  exit 1
fi

"./${obj_dir}/${sim_binary}" > "${log_file}" 2>&1
sim_status=$?
cat "${log_file}"
if [ ${sim_status} -ne 0 ]; then
  echo "Simulation exited with status ${sim_status}"
  exit 1
fi

if grep -qx "TB PASSED" "${log_file}"; then
  echo "Simulation passed"
  exit 0
fi

echo "Pass message not found in ${log_file}"
exit 1
